// ==== rtl/ecc_mem_pkg.sv ====
//////////////////////////////////////////////////
// Sizes, codeword union and Hsiao (39,32) check
// matrix shared by the ECC memory stages
//////////////////////////////////////////////////

package ecc_mem_pkg;

  // Data and check widths of the Hsiao (39,32) code
  localparam int DataW  = 32;
  localparam int CheckW = 7;
  localparam int CodeW  = DataW + CheckW;

  // Memory geometry
  localparam int Depth = 128;
  localparam int AddrW = $clog2(Depth);

  // Check bits sit above the data bits in a stored codeword
  typedef struct packed {
    logic [CheckW-1:0] check;
    logic [DataW-1:0]  data;
  } ecc_word_s;

  // The same 39 bits seen as fields or as one flat vector
  typedef union packed {
    ecc_word_s        fields;
    logic [CodeW-1:0] raw;
  } ecc_word_u;

  // Row i selects the data bits that check bit i covers
  // Data bit j takes the j-th weight-3 column in lexicographic order of row triples
  // Every column is therefore odd, distinct and never a single row
  localparam logic [CheckW-1:0][DataW-1:0] EccHMatrix = '{
    32'h69A4_6910,
    32'hD552_5488,
    32'hB2C9_3244,
    32'h8E38_8E22,
    32'h7E07_81E1,
    32'h01FF_801F,
    32'h0000_7FFF
  };

endpackage

// ==== rtl/mem_req_if.sv ====
//////////////////////////////////////////////////
// Encoded memory request from decode to the RAM
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface mem_req_if import ecc_mem_pkg::*; ();

  // One request per cycle while req is high
  logic             req;
  logic             write;
  logic [AddrW-1:0] addr;
  // Encoded codeword for writes
  ecc_word_u        wdata;

  // The decode stage drives the request
  modport src (output req, write, addr, wdata);

  // The RAM only samples it
  modport dst (input req, write, addr, wdata);

endinterface

// ==== rtl/ecc_req_decode.sv ====
//////////////////////////////////////////////////
// Request stage with Hsiao ECC encoding
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ecc_req_decode import ecc_mem_pkg::*; (
  input  logic             req_i,
  input  logic             write_i,
  input  logic [AddrW-1:0] addr_i,
  input  logic [DataW-1:0] wdata_i,
  mem_req_if.src           req_o
);

  // A write is only real when a request is present
  logic             is_write;
  // Check bits computed over the write data
  logic [CheckW-1:0] check_bits;
  ecc_word_u        code_word;

  assign is_write = req_i & write_i;

  // Each check bit is the even parity of the data bits picked by its row
  always_comb begin
    check_bits = '0;
    for (int i = 0; i < CheckW; i++) begin
      check_bits[i] = ^(wdata_i & EccHMatrix[i]);
    end
  end

  // Build the codeword through its field view
  // Reads leave the data unencoded and the check field at zero
  always_comb begin
    code_word.fields.data = wdata_i;
    if (is_write) begin
      code_word.fields.check = check_bits;
    end else begin
      code_word.fields.check = '0;
    end
  end

  // Request, direction and address pass straight through in the same cycle
  assign req_o.req   = req_i;
  assign req_o.write = write_i;
  assign req_o.addr  = addr_i;
  assign req_o.wdata = code_word;

endmodule

// ==== rtl/badbit_ram_1p.sv ====
//////////////////////////////////////////////////
// Single-port codeword RAM with read fault masks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module badbit_ram_1p import ecc_mem_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  mem_req_if.dst           req_i,
  input  logic [CodeW-1:0] fault_mask_i,
  output ecc_word_u        rdata_o,
  output logic             rd_pending_o
);

  // Codeword storage for every address
  logic [CodeW-1:0] mem [Depth];
  // Registered read port output before corruption
  logic [CodeW-1:0] rd_raw_q;
  logic             rd_req;
  logic             wr_req;

  assign wr_req = req_i.req & req_i.write;
  assign rd_req = req_i.req & ~req_i.write;

  // Write and read share one address and one clock edge
  always_ff @(posedge clk_i) begin
    if (wr_req) begin
      mem[req_i.addr] <= req_i.wdata.raw;
    end
    if (rd_req) begin
      rd_raw_q <= mem[req_i.addr];
    end
  end

  // Marks the cycle in which rd_raw_q holds fresh read data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_pending_o <= 1'b0;
    end else begin
      rd_pending_o <= rd_req;
    end
  end

  // The fault mask flips bits of the response combinationally
  // A set mask bit never reaches the stored word, so later reads see clean data
  always_comb begin
    rdata_o.raw = rd_raw_q ^ fault_mask_i;
  end

endmodule

// ==== rtl/ecc_result_check.sv ====
//////////////////////////////////////////////////
// Syndrome check, single-bit correction, double-bit
// detection and the registered read response
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ecc_result_check import ecc_mem_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  input  ecc_word_u        rdata_i,
  input  logic             rd_pending_i,
  output logic             rvalid_o,
  output logic [DataW-1:0] rdata_o,
  output logic             err_corr_o,
  output logic             err_uncorr_o
);

  logic [CheckW-1:0] syndrome;
  // Column of the check matrix under test in the match loop
  logic [CheckW-1:0] column;
  // Data bit to flip when the syndrome names a data column
  logic [DataW-1:0]  flip_mask;
  logic              col_hit;
  logic              syn_odd;
  logic              syn_zero;
  logic              chk_only;
  logic              corr;
  logic              uncorr;
  logic [DataW-1:0]  data_fixed;

  // Recomputed parity against the stored check field
  always_comb begin
    syndrome = '0;
    for (int i = 0; i < CheckW; i++) begin
      syndrome[i] = ^(rdata_i.fields.data & EccHMatrix[i]) ^ rdata_i.fields.check[i];
    end
  end

  // Look for the data column that equals the syndrome
  always_comb begin
    flip_mask = '0;
    col_hit   = 1'b0;
    column    = '0;
    for (int j = 0; j < DataW; j++) begin
      for (int i = 0; i < CheckW; i++) begin
        column[i] = EccHMatrix[i][j];
      end
      if (column == syndrome) begin
        flip_mask[j] = 1'b1;
        col_hit      = 1'b1;
      end
    end
  end

  assign syn_zero = (syndrome == '0);
  assign syn_odd  = ^syndrome;
  // A weight-one syndrome points at a check bit and leaves the data untouched
  assign chk_only = ~syn_zero & ((syndrome & (syndrome - 1'b1)) == '0);

  // Odd syndromes that match a column or a single check bit are correctable
  assign corr   = syn_odd & (col_hit | chk_only);
  // Even nonzero syndromes and odd ones with no match are not
  assign uncorr = ~syn_zero & ~corr;

  // flip_mask stays zero unless a data column matched
  assign data_fixed = rdata_i.fields.data ^ flip_mask;

  // Valid and flags return to zero whenever no read is pending
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o     <= 1'b0;
      err_corr_o   <= 1'b0;
      err_uncorr_o <= 1'b0;
    end else begin
      rvalid_o     <= rd_pending_i;
      err_corr_o   <= rd_pending_i & corr;
      err_uncorr_o <= rd_pending_i & uncorr;
    end
  end

  // Response data only loads on a pending read
  always_ff @(posedge clk_i) begin
    if (rd_pending_i) begin
      rdata_o <= data_fixed;
    end
  end

endmodule

// ==== rtl/ecc_mem_top.sv ====
//////////////////////////////////////////////////
// ECC-protected SRAM with read fault injection
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ecc_mem_top import ecc_mem_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             req_i,
  input  logic             write_i,
  input  logic [AddrW-1:0] addr_i,
  input  logic [DataW-1:0] wdata_i,
  input  logic [CodeW-1:0] fault_mask_i,
  output logic             rvalid_o,
  output logic [DataW-1:0] rdata_o,
  output logic             err_corr_o,
  output logic             err_uncorr_o
);

  // Encoded request from decode into the RAM
  mem_req_if u_req_if ();

  // Corrupted read word and its valid marker
  ecc_word_u rdata_word;
  logic      rd_pending;

  // Encodes writes with no added latency
  ecc_req_decode u_decode (
    .req_i   (req_i),
    .write_i (write_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .req_o   (u_req_if.src)
  );

  // Storage with the test-driven fault mask on its read response
  badbit_ram_1p u_ram (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (u_req_if.dst),
    .fault_mask_i (fault_mask_i),
    .rdata_o      (rdata_word),
    .rd_pending_o (rd_pending)
  );

  // Corrects or flags the word and registers the response
  ecc_result_check u_check (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rdata_i      (rdata_word),
    .rd_pending_i (rd_pending),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .err_corr_o   (err_corr_o),
    .err_uncorr_o (err_uncorr_o)
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
//////////////////////////////////////////////////
// Free-running testbench clock with an 8 ns period
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  // Starts low so the first rising edge lands at 4 ns
  initial begin
    clk_o = 1'b0;
  end

  // Half of the 8 ns period
  always begin
    #4 clk_o = ~clk_o;
  end

endmodule

// ==== sim/ecc_mem_tb.sv ====
//////////////////////////////////////////////////
// Trace-driven testbench for the ECC memory with a
// reference memory, response queue and watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ecc_mem_tb import ecc_mem_pkg::*; ();

  localparam int MaxLines    = 64;
  localparam int RandReads   = 16;
  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 5;

  logic             clk;
  logic             rst;
  logic             req;
  logic             write;
  logic [AddrW-1:0] addr;
  logic [DataW-1:0] wdata;
  logic [CodeW-1:0] fault_mask;
  logic             rvalid;
  logic [DataW-1:0] rdata;
  logic             err_corr;
  logic             err_uncorr;

  // Trace lines as loaded from the file
  logic [7:0]       tr_op   [MaxLines];
  logic [AddrW-1:0] tr_addr [MaxLines];
  logic [DataW-1:0] tr_data [MaxLines];
  logic [CodeW-1:0] tr_mask [MaxLines];
  int               tr_class[MaxLines];
  int               n_lines;
  logic             trace_loaded;

  // Reference copy of every word written so far
  logic [DataW-1:0] ref_mem [Depth];
  logic [AddrW-1:0] written_q[$];

  // Outstanding reads in issue order
  logic [DataW-1:0] exp_data_q[$];
  int               exp_class_q[$];
  int               exp_cycle_q[$];

  // A read's mask goes out one cycle after the read itself
  logic [CodeW-1:0] pending_mask;
  int               cycle;
  int               errors;
  int               checks;

  tb_clk_gen u_clk_gen (
    .clk_o (clk)
  );

  ecc_mem_top dut (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_i        (req),
    .write_i      (write),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .fault_mask_i (fault_mask),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .err_corr_o   (err_corr),
    .err_uncorr_o (err_uncorr)
  );

  task automatic check_val(input logic [DataW-1:0] actual, input logic [DataW-1:0] expected,
                           input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Lines starting with # are comments and every other line holds five columns
  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    logic [CodeW-1:0] m;
    int          c;
    fd = $fopen("sim/ecc_mem_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("The trace file sim/ecc_mem_trace.txt could not be opened");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          if (line.len() > 0 && line[0] != "#") begin
            n = $sscanf(line, "%c %h %h %h %d", op, a, d, m, c);
            if (n == 5 && n_lines < MaxLines) begin
              tr_op[n_lines]    = op;
              tr_addr[n_lines]  = a[AddrW-1:0];
              tr_data[n_lines]  = d;
              tr_mask[n_lines]  = m;
              tr_class[n_lines] = c;
              n_lines++;
            end else if (n == 5) begin
              errors++;
              $display("The trace holds more than %0d operations, the rest was ignored", MaxLines);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Compares a response against the oldest outstanding read
  task automatic collect_response();
    logic [DataW-1:0] exp_d;
    int               exp_c;
    int               exp_cyc;
    if (rvalid) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("A read response arrived at %0t ns with no read outstanding", $time);
      end else begin
        exp_d   = exp_data_q.pop_front();
        exp_c   = exp_class_q.pop_front();
        exp_cyc = exp_cycle_q.pop_front();
        check_val(32'(cycle), 32'(exp_cyc), "response cycle");
        check_val(rdata, exp_d, "rdata_o");
        check_val(32'(err_corr), 32'(exp_c == 1), "err_corr_o");
        check_val(32'(err_uncorr), 32'(exp_c == 2), "err_uncorr_o");
      end
    end else begin
      // Flags must stay low between responses
      check_val(32'(err_corr), 32'd0, "err_corr_o while idle");
      check_val(32'(err_uncorr), 32'd0, "err_uncorr_o while idle");
    end
  endtask

  // Each clock cycle samples the response and then drives the next request
  // For reads, data is the expected response data
  task automatic step(input logic do_req, input logic do_write, input logic [AddrW-1:0] a,
                      input logic [DataW-1:0] d, input logic [CodeW-1:0] m, input int cls);
    @(negedge clk);
    cycle++;
    collect_response();
    fault_mask   = pending_mask;
    pending_mask = '0;
    req          = do_req;
    write        = do_write;
    addr         = a;
    wdata        = do_write ? d : '0;
    if (do_req && do_write) begin
      ref_mem[a] = d;
      written_q.push_back(a);
    end
    if (do_req && !do_write) begin
      pending_mask = m;
      exp_data_q.push_back(d);
      exp_class_q.push_back(cls);
      // The RAM and the check stage each add one register after the sampling edge
      exp_cycle_q.push_back(cycle + 2);
    end
  endtask

  initial begin : main
    int               idx;
    logic [AddrW-1:0] a;
    req          = 1'b0;
    write        = 1'b0;
    addr         = '0;
    wdata        = '0;
    fault_mask   = '0;
    rst          = 1'b1;
    pending_mask = '0;
    cycle        = 0;
    errors       = 0;
    checks       = 0;
    n_lines      = 0;
    trace_loaded = 1'b0;
    void'($urandom(96796));
    load_trace();
    trace_loaded = 1'b1;

    repeat (ResetCycles) @(negedge clk);
    check_val(32'(rvalid), 32'd0, "rvalid_o after reset");
    check_val(32'(err_corr), 32'd0, "err_corr_o after reset");
    check_val(32'(err_uncorr), 32'd0, "err_uncorr_o after reset");
    rst = 1'b0;

    for (int i = 0; i < n_lines; i++) begin
      step(1'b1, tr_op[i] == "W", tr_addr[i], tr_data[i], tr_mask[i], tr_class[i]);
    end

    // Clean reads of random written words after the faults above
    for (int i = 0; i < RandReads && written_q.size() > 0; i++) begin
      idx = $urandom_range(written_q.size() - 1, 0);
      a   = written_q[idx];
      step(1'b1, 1'b0, a, ref_mem[a], '0, 0);
    end

    // Idle cycles until the last responses are back
    for (int k = 0; k < 4 && exp_data_q.size() > 0; k++) begin
      step(1'b0, 1'b0, '0, '0, '0, 0);
    end
    if (exp_data_q.size() > 0) begin
      errors++;
      $display("%0d read responses never arrived", exp_data_q.size());
    end

    $display("Checks done: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Budget covers every trace line and random read plus a fixed margin
  initial begin : watchdog
    int limit_ns;
    wait (trace_loaded === 1'b1);
    limit_ns = (n_lines + RandReads + 20) * ClkPeriod;
    #(limit_ns);
    $display("Watchdog timeout: the run did not finish within %0d ns", limit_ns);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== sim/ecc_mem_trace.txt ====
# op addr data fault_mask class; W writes data, R expects data as the response
# fault_mask is 39 bits with check bits 38..32, class 0 clean, 1 corrected, 2 uncorrected
W 00 DEADBEEF 0000000000 0
W 01 12345678 0000000000 0
W 02 A5A5A5A5 0000000000 0
W 03 FFFFFFFF 0000000000 0
W 04 00000000 0000000000 0
W 05 0F0F0F0F 0000000000 0
W 06 CAFEF00D 0000000000 0
W 07 80000001 0000000000 0
W 7F 13579BDF 0000000000 0
W 40 2468ACE0 0000000000 0
# Clean reads back to back
R 00 DEADBEEF 0000000000 0
R 01 12345678 0000000000 0
R 02 A5A5A5A5 0000000000 0
R 7F 13579BDF 0000000000 0
# Read right after a write to the same address
W 10 55AA33CC 0000000000 0
R 10 55AA33CC 0000000000 0
W 11 0BADCAFE 0000000000 0
R 11 0BADCAFE 0000000000 0
W 00 FEEDFACE 0000000000 0
R 00 FEEDFACE 0000000000 0
# Single data bit errors
R 01 12345678 0000000001 1
R 02 A5A5A5A5 0080000000 1
R 03 FFFFFFFF 0000010000 1
R 04 00000000 0000000100 1
R 40 2468ACE0 0000000800 1
# Single check bit errors
R 05 0F0F0F0F 0100000000 1
R 06 CAFEF00D 4000000000 1
R 07 80000001 0800000000 1
# Double bit errors return the data field uncorrected
R 03 FFFFFFFC 0000000003 2
R 04 80000001 0080000001 2
R 05 0F0F0F1F 0100000010 2
R 06 CAFEF00D 6000000000 2
R 02 A5A6A5A5 0000030000 2
# Stored words are untouched by earlier faults
R 01 12345678 0000000000 0
R 03 FFFFFFFF 0000000000 0
R 06 CAFEF00D 0000000000 0

// ==== all.f ====
rtl/ecc_mem_pkg.sv
rtl/mem_req_if.sv
rtl/ecc_req_decode.sv
rtl/badbit_ram_1p.sv
rtl/ecc_result_check.sv
rtl/ecc_mem_top.sv
sim/tb_clk_gen.sv
sim/ecc_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run from the project root and judge the result from the log
verilator --binary --timing --top-module ecc_mem_tb -Mdir obj_dir -o ecc_mem_sim -f all.f \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/ecc_mem_sim > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0
